// File: hw/tile_bus_decode.sv
/*
 * Wishbone slave for the tile layer
 * Decodes VRAM, scroll and palette accesses, single-cycle ack
 */
`timescale 1ns/10ps
`default_nettype none

module tile_bus_decode (
    input  logic                            clk,
    input  logic                            rst,
    input  tilemap_pkg::wb_req_t            wb_req,
    output logic [7:0]                      wb_dat_r,
    output logic                            wb_ack,
    output tilemap_pkg::vram_wr_t           vram_wr,
    output logic [tilemap_pkg::VRAM_AW-1:0] vram_cpu_addr,
    input  logic [15:0]                     vram_cpu_q,
    output logic                            scr_we,
    input  logic [7:0]                      scr_q,
    output tilemap_pkg::pal_wr_t            pal_wr
);
    import tilemap_pkg::*;

    logic req;
    logic held;      // Request already acked, waiting for stb to drop
    logic start;     // First cycle of a new request
    logic wr;
    logic sel_vram;
    logic sel_scr;
    logic sel_pal;
    logic hi_lane;   // Tile code byte

    assign req   = wb_req.cyc & wb_req.stb;
    assign start = req & ~wb_ack & ~held;
    assign wr    = start & wb_req.we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
            held   <= 1'b0;
        end else begin
            wb_ack <= start;
            held   <= req & (held | wb_ack);  // Cleared once the master lets go
        end
    end

    // Address map
    assign sel_vram = ~wb_req.adr[11];              // 0x000-0x7FF
    assign sel_scr  = wb_req.adr == 12'h800;
    assign sel_pal  = wb_req.adr[11:8] == 4'hC;     // 0xC00-0xCFF
    assign hi_lane  = wb_req.adr[10];

    assign vram_wr.we    = {2{wr & sel_vram}} & {hi_lane, ~hi_lane};
    assign vram_wr.addr  = wb_req.adr[VRAM_AW-1:0];
    assign vram_wr.data  = wb_req.dat;
    assign vram_cpu_addr = wb_req.adr[VRAM_AW-1:0];  // Word lands in the ack cycle

    assign scr_we = wr & sel_scr;

    assign pal_wr.we   = wr & sel_pal;
    assign pal_wr.addr = wb_req.adr[7:0];
    assign pal_wr.data = wb_req.dat[3:0];

    // Read data, valid while wb_ack is high
    always_comb begin
        if (sel_vram) begin
            wb_dat_r = hi_lane ? vram_cpu_q[15:8] : vram_cpu_q[7:0];
        end else if (sel_scr) begin
            wb_dat_r = scr_q;
        end else begin
            wb_dat_r = 8'd0;  // Palette is write only
        end
    end

endmodule

`default_nettype wire

// File: hw/tile_palette.sv
/*
 * Tile palette PROM, 256 x 4
 * CPU writable, read registered on the pixel enable
 */
`timescale 1ns/10ps
`default_nettype none

module tile_palette (
    input  logic                 clk,
    input  logic                 pxl_cen,
    input  tilemap_pkg::pal_wr_t pal_wr,
    input  logic [7:0]           pal_addr,   // {pal, nibble}
    output logic [3:0]           pxl
);

    logic [3:0] mem [0:255];

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            mem[pal_wr.addr] <= pal_wr.data;
        end
        // One pixel of latency
        if (pxl_cen) begin
            pxl <= mem[pal_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/tile_scroll_layer.sv
/*
 * Tile scroll layer
 * Column scroll, tile map fetch, graphics ROM addressing
 * and 4-bit pixel shifter feeding the palette
 */
`timescale 1ns/10ps
`default_nettype none

module tile_scroll_layer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pxl_cen,
    input  tilemap_pkg::vid_pos_t           vpos,
    input  logic                            flip,
    input  logic                            scr_we,
    input  logic [7:0]                      scr_din,
    output logic [7:0]                      scr_q,
    output logic [tilemap_pkg::VRAM_AW-1:0] vram_addr,
    input  logic [15:0]                     vram_q,
    output logic [12:0]                     rom_addr,
    input  logic [31:0]                     rom_data,
    output logic [7:0]                      pal_addr
);
    import tilemap_pkg::*;

    logic [7:0]  hdf;        // Column index after flip
    logic [7:0]  vline;      // Line index after flip, before scroll
    logic [7:0]  vscr;       // Source line of current column
    logic        score;      // Column inside fixed score area
    logic [7:0]  code;
    tile_attr_t  attr;
    logic        fetch_hf;   // Held from ROM address to data load
    logic [3:0]  fetch_pal;
    logic        cur_hf;     // Tile being shifted out
    logic [3:0]  cur_pal;
    logic [31:0] pxl_data;

    // Flipped columns run backwards, offset by 3 to keep tile alignment
    assign hdf   = flip ? (~vpos.hdump[7:0] - 8'd3) : vpos.hdump[7:0];
    assign vline = {8{flip}} ^ vpos.vdump;
    assign score = flip ? (hdf < 8'(SCRCOL)) : (vpos.hdump < 9'(SCRCOL));

    assign code = vram_q[15:8];
    assign attr = vram_q[7:0];

    // Scroll register and per-column source line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scr_q <= 8'd0;
            vscr  <= 8'd0;
        end else begin
            if (scr_we) begin
                scr_q <= scr_din;
            end
            if (score) begin
                vscr <= vline;                   // Score columns never scroll
            end else begin
                vscr <= vline + scr_q + 8'd1;    // Wraps mod 256
            end
        end
    end

    // 32 x 32 tile map, row then column
    assign vram_addr = {vscr[7:3], hdf[7:3]};

    // Per 8-pixel group: address at 0, data at 4, then shift
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (vpos.hdump[2:0] == 3'd0) begin
                rom_addr  <= {attr.code_msb, code, vscr[2:0] ^ {3{attr.vflip}}};
                fetch_hf  <= attr.hflip ^ flip;
                fetch_pal <= attr.pal;
            end
            if (vpos.hdump[2:0] == 3'd4) begin
                pxl_data <= rom_data;    // ROM has had 4 pixel periods
                cur_hf   <= fetch_hf;
                cur_pal  <= fetch_pal;
            end else if (cur_hf) begin
                pxl_data <= pxl_data >> 4;
            end else begin
                pxl_data <= pxl_data << 4;
            end
        end
    end

    // Mirrored tiles start from the low nibble
    assign pal_addr = {cur_pal, cur_hf ? pxl_data[3:0] : pxl_data[31:28]};

endmodule

`default_nettype wire

// File: hw/tile_vram.sv
/*
 * Tile map RAM, 1K x 16
 * CPU port with byte-lane writes, read-only video port
 */
`timescale 1ns/10ps
`default_nettype none

module tile_vram (
    input  logic                            clk,
    input  tilemap_pkg::vram_wr_t           vram_wr,
    input  logic [tilemap_pkg::VRAM_AW-1:0] cpu_addr,
    output logic [15:0]                     cpu_q,
    input  logic [tilemap_pkg::VRAM_AW-1:0] vid_addr,
    output logic [15:0]                     vid_q
);
    import tilemap_pkg::*;

    // Code in the high byte, attribute in the low byte
    logic [15:0] mem [0:(1 << VRAM_AW) - 1];

    // CPU port
    always_ff @(posedge clk) begin
        if (vram_wr.we[0]) begin
            mem[vram_wr.addr][7:0] <= vram_wr.data;
        end
        if (vram_wr.we[1]) begin
            mem[vram_wr.addr][15:8] <= vram_wr.data;
        end
        cpu_q <= mem[cpu_addr];  // Old word on a same-address write
    end

    // Video port
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

`default_nettype wire

// File: hw/tilemap_pkg.sv
/*
 * Tile scroll layer shared definitions
 * Layout constants and bus, VRAM, palette and beam position records
 */
`default_nettype none

package tilemap_pkg;

    localparam int VRAM_AW    = 10;   // 1K word tile map
    localparam int HTOTAL     = 384;  // Pixels per line
    localparam int VTOTAL     = 264;  // Lines per frame
    localparam int HVIS       = 256;
    localparam int VVIS_START = 16;
    localparam int VVIS_END   = 239;
    localparam int CEN_DIV    = 4;    // Clocks per pixel
    localparam int SCRCOL     = 32;   // Score area ends here
    localparam int PIPE_DLY   = 6;    // hdump to pxl latency

    // Wishbone classic request from the CPU side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic [1:0]         we;    // High lane is tile code
        logic [VRAM_AW-1:0] addr;
        logic [7:0]         data;
    } vram_wr_t;

    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        logic [3:0] data;
    } pal_wr_t;

    // Attribute byte, MSB first
    typedef struct packed {
        logic [1:0] code_msb;
        logic       vflip;
        logic       hflip;
        logic [3:0] pal;
    } tile_attr_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [7:0] vdump;
        logic       lhbl;   // High in active line
        logic       lvbl;   // High in active frame
    } vid_pos_t;

endpackage

`default_nettype wire

// File: hw/tilemap_top.sv
/*
 * Tile scroll layer top level
 * Bus decode, tile map RAM, video timing, layer and palette
 */
`timescale 1ns/10ps
`default_nettype none

module tilemap_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flip,
    input  tilemap_pkg::wb_req_t  wb_req,
    output logic [7:0]            wb_dat_r,
    output logic                  wb_ack,
    output logic [12:0]           rom_addr,   // External graphics ROM
    input  logic [31:0]           rom_data,
    output logic [3:0]            pxl,
    output tilemap_pkg::vid_pos_t vpos,
    output logic                  pxl_cen
);
    import tilemap_pkg::*;

    vram_wr_t           vram_wr;
    logic [VRAM_AW-1:0] vram_cpu_addr;
    logic [15:0]        vram_cpu_q;
    logic [VRAM_AW-1:0] vram_vid_addr;
    logic [15:0]        vram_vid_q;
    logic               scr_we;
    logic [7:0]         scr_q;
    pal_wr_t            pal_wr;
    logic [7:0]         pal_addr;

    tile_bus_decode decode_i (
        .clk           (clk),
        .rst           (rst),
        .wb_req        (wb_req),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .vram_wr       (vram_wr),
        .vram_cpu_addr (vram_cpu_addr),
        .vram_cpu_q    (vram_cpu_q),
        .scr_we        (scr_we),
        .scr_q         (scr_q),
        .pal_wr        (pal_wr)
    );

    tile_vram vram_i (
        .clk      (clk),
        .vram_wr  (vram_wr),
        .cpu_addr (vram_cpu_addr),
        .cpu_q    (vram_cpu_q),
        .vid_addr (vram_vid_addr),
        .vid_q    (vram_vid_q)
    );

    video_timing timing_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .vpos    (vpos)
    );

    tile_scroll_layer layer_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .vpos      (vpos),
        .flip      (flip),
        .scr_we    (scr_we),
        .scr_din   (wb_req.dat),   // Scroll data straight off the bus
        .scr_q     (scr_q),
        .vram_addr (vram_vid_addr),
        .vram_q    (vram_vid_q),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pal_addr  (pal_addr)
    );

    tile_palette palette_i (
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .pal_wr   (pal_wr),
        .pal_addr (pal_addr),
        .pxl      (pxl)
    );

endmodule

`default_nettype wire

// File: hw/video_timing.sv
/*
 * Video timing
 * Pixel clock enable, beam counters and blanking flags
 */
`timescale 1ns/10ps
`default_nettype none

module video_timing (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  pxl_cen,
    output tilemap_pkg::vid_pos_t vpos
);
    import tilemap_pkg::*;

    logic [1:0] cen_cnt;
    logic [8:0] hcnt;
    logic [8:0] vcnt;   // 264 lines need a ninth bit

    // Divide clk down to the pixel rate
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= (cen_cnt == 2'(CEN_DIV - 1)) ? 2'd0 : cen_cnt + 2'd1;
        end
    end

    assign pxl_cen = cen_cnt == 2'(CEN_DIV - 1);  // First high on fourth clock

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == 9'(HTOTAL - 1)) begin
                hcnt <= '0;
                // Next line, wrap at end of frame
                vcnt <= (vcnt == 9'(VTOTAL - 1)) ? 9'd0 : vcnt + 9'd1;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    assign vpos.hdump = hcnt;
    assign vpos.vdump = vcnt[7:0];  // Lines 256+ alias into vblank
    assign vpos.lhbl  = hcnt < 9'(HVIS);
    assign vpos.lvbl  = (vcnt >= 9'(VVIS_START)) && (vcnt <= 9'(VVIS_END));

endmodule

`default_nettype wire

// File: tb/tilemap_tb.sv
/*
 * Testbench for the tile scroll layer
 * Replays bus accesses from the testdata file, models the graphics ROM
 * and compares read data and pixels with the listed values
 */
`timescale 1ns/10ps
`default_nettype none

module tilemap_tb;
    import tilemap_pkg::*;

    localparam int ACK_TIMEOUT  = 10;                          // Clocks
    localparam int FRAME_CLOCKS = HTOTAL * VTOTAL * CEN_DIV;
    localparam int SYNC_LINE    = 8;   // Vblank line, ahead of every checked line

    logic        clk = 1'b0;
    logic        rst;
    logic        flip;
    wb_req_t     wb_req;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic [12:0] rom_addr;
    logic [31:0] rom_q1   = '0;   // First ROM pipeline stage
    logic [31:0] rom_data = '0;
    logic [3:0]  pxl;
    vid_pos_t    vpos;
    logic        pxl_cen;

    int          fd;
    int          n_checks;
    logic        dirty;   // Tile map, scroll or flip touched since last frame sync

    tilemap_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .flip     (flip),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .pxl      (pxl),
        .vpos     (vpos),
        .pxl_cen  (pxl_cen)
    );

    always #10 clk = ~clk;   // 20 ns period

    // Graphics ROM contents, nibble k of word a is (a + k) mod 16, MSB first
    function automatic logic [31:0] rom_word(input logic [12:0] a);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            w[31 - 4*k -: 4] = 4'(a + 13'(k));
        end
        return w;
    endfunction

    // Two clocks from address to data
    always @(posedge clk) begin
        rom_q1   <= rom_word(rom_addr);
        rom_data <= rom_q1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_pxl(input string name, input logic [3:0] got, input logic [3:0] exp);
        n_checks++;
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // One Wishbone classic cycle, request held until ack
    task automatic bus_access(input logic we, input logic [11:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdata);
        int waited;
        @(posedge clk);
        #2;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        waited = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                fail_run($sformatf("No bus ack within %0d clocks at address %h",
                                   ACK_TIMEOUT, adr));
            end
            @(negedge clk);
        end
        if (waited != 1) begin
            fail_run($sformatf("Bus ack at address %h came %0d clocks after the request",
                               adr, waited));
        end
        rdata = wb_dat_r;   // Read byte valid in the ack cycle
        @(posedge clk);
        #2;
        check_bit("wb_ack", wb_ack, 1'b0);   // Ack lasts one clock with the request still up
        wb_req = '0;
    endtask

    // Stop at the pixel enable of a given beam position
    task automatic wait_beam(input logic [7:0] line, input logic [8:0] hpos);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(pxl_cen && vpos.vdump == line && vpos.hdump == hpos)) begin
            waited++;
            if (waited > FRAME_CLOCKS) begin
                fail_run($sformatf("Beam never reached line %0d hdump %0d within a frame",
                                   line, hpos));
            end
            @(negedge clk);
        end
    endtask

    // Blanking flags at one beam position
    task automatic blanking_at(input logic [7:0] line, input logic [8:0] hpos,
                               input logic exp_lhbl, input logic exp_lvbl);
        wait_beam(line, hpos);
        check_bit($sformatf("lhbl at line %0d hdump %0d", line, hpos),
                  vpos.lhbl, exp_lhbl);
        check_bit($sformatf("lvbl at line %0d hdump %0d", line, hpos),
                  vpos.lvbl, exp_lvbl);
    endtask

    initial begin : run
        logic [7:0]     kind;
        logic [11:0]    adr;
        logic [7:0]     dat;
        logic [7:0]     rdata;
        logic [7:0]     line;
        logic [8:0]     col;
        logic [3:0]     value;
        int             tmp;
        int             n;
        logic [1023:0]  rest;   // Remainder of a comment line
        rst      = 1'b1;
        flip     = 1'b0;
        wb_req   = '0;
        dirty    = 1'b1;
        n_checks = 0;
        fd = $fopen("tb/tilemap_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open tb/tilemap_testdata.txt");
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        // No ack on an idle bus and pixel enable on every fourth clock
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_bit("wb_ack", wb_ack, 1'b0);
            check_bit("pxl_cen", pxl_cen, (i % 4) == 3);
        end
        // Visible area is hdump 0 to 255 on lines 16 to 239
        blanking_at(8'd15, 9'd0, 1'b1, 1'b0);
        blanking_at(8'd16, 9'd255, 1'b1, 1'b1);
        blanking_at(8'd16, 9'd256, 1'b0, 1'b1);
        blanking_at(8'd239, 9'd383, 1'b0, 1'b1);
        blanking_at(8'd240, 9'd0, 1'b1, 1'b0);
        n = $fscanf(fd, " %c", kind);
        while (n == 1) begin
            case (kind)
                "#": n = $fgets(rest, fd);
                "W": begin
                    n = $fscanf(fd, "%h %h", adr, dat);
                    bus_access(1'b1, adr, dat, rdata);
                    dirty = 1'b1;
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", adr, dat);
                    bus_access(1'b0, adr, 8'h00, rdata);
                    check_byte($sformatf("wb_dat_r at %h", adr), rdata, dat);
                end
                "F": begin
                    n = $fscanf(fd, "%h", tmp);
                    @(posedge clk);
                    #2;
                    flip  = tmp[0];
                    dirty = 1'b1;
                end
                "P": begin
                    n = $fscanf(fd, "%h %h %h", line, col, value);
                    if (dirty) begin
                        wait_beam(8'(SYNC_LINE), 9'd0);   // Whole frame with new setup
                        dirty = 1'b0;
                    end
                    wait_beam(line, col + 9'(PIPE_DLY));
                    check_pxl($sformatf("pxl line %0d col %0d", line, col), pxl, value);
                end
                default: fail_run($sformatf("Unknown record kind %c in testdata", kind));
            endcase
            if (n < 1) begin
                fail_run("Malformed record in testdata");
            end
            n = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
        if (n_checks > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_run("Testdata held no checks");
        end
    end

endmodule

`default_nettype wire

// File: tb/tilemap_testdata.txt
# W addr data | R addr expected | F flip | P line col expected_pixel
# All fields hex, addr is the 12-bit Wishbone address
R 800 00
# Scroll 0: tiles at row 5, columns 1 (score) and 6
W 4A1 12
W 0A1 01
W 4A6 35
W 0A6 42
R 4A1 12
R 0A1 01
R 4A6 35
R 0A6 42
W C10 03
W C13 09
W C29 0C
W C20 05
W C11 07
R C10 00
P 028 08 3
P 028 0B 9
P 028 30 C
P 028 37 5
# Scroll 0x17: plain, hflip and vflip tiles on row 8
W 800 17
R 800 17
W 506 20
W 106 03
W 507 21
W 107 13
W 508 22
W 108 23
W C32 0A
W C3F 01
W C3A 0E
W C34 06
W C37 0B
P 028 09 7
P 028 32 A
P 028 38 1
P 028 3D E
P 02B 40 6
P 02B 43 B
# Flip on: row 9 column 21 and score tile at row 6 column 1
W 535 40
W 135 04
W 4C1 41
W 0C1 04
W C4E 02
W C48 0D
W C46 08
W C43 0F
F 1
P 0C8 50 2
P 0C8 56 D
P 0C8 F0 8
P 0C8 F3 F

// File: tilemap_top.f
hw/tilemap_pkg.sv
hw/video_timing.sv
hw/tile_bus_decode.sv
hw/tile_vram.sv
hw/tile_scroll_layer.sv
hw/tile_palette.sv
hw/tilemap_top.sv
tb/tilemap_tb.sv
